// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_timer_subsys
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
hw/soc_bus_pkg.sv
hw/soc_timer_pkg.sv
hw/axil_slave_port.sv
hw/riscv_mtimer.sv
hw/axil_resp_channels.sv
hw/timer_subsys_top.sv
testbench/tb_timer_subsys.sv

// File: hw/axil_resp_channels.sv
/* AXI4-Lite response side: one pending B and one pending R,
   each held until the master takes it */
`timescale 1ns/100ps

module axil_resp_channels (
	input  logic                       clk,
	input  logic                       rst_n,
	input  soc_timer_pkg::reg_access_t access,
	input  logic                       err_req,
	input  soc_bus_pkg::axil_data_t    rdata,
	input  logic                       bready,
	input  logic                       rready,
	output soc_bus_pkg::axil_b_t       b,
	output soc_bus_pkg::axil_r_t       r,
	output logic                       b_busy,
	output logic                       r_busy
);

	logic b_pend;
	logic r_pend;
	logic b_err;
	logic r_err;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			b_pend <= 1'b0;
			r_pend <= 1'b0;
		end else begin
			if (b_pend && bready) begin
				b_pend <= 1'b0;
			end
			if (access.wen) begin
				b_pend <= 1'b1;
			end
			if (r_pend && rready) begin
				r_pend <= 1'b0;
			end
			if (access.ren) begin
				r_pend <= 1'b1;
			end
		end
	end

	// decode result captured with the access
	always_ff @(posedge clk) begin
		if (access.wen) begin
			b_err <= err_req;
		end
		if (access.ren) begin
			r_err <= err_req;
		end
	end

	assign b.valid = b_pend;
	assign b.resp  = b_err ? soc_bus_pkg::resp_decerr : soc_bus_pkg::resp_okay;

	// timer read data stays stable while r is pending
	assign r.valid = r_pend;
	assign r.data  = r_err ? '0 : rdata;
	assign r.resp  = r_err ? soc_bus_pkg::resp_decerr : soc_bus_pkg::resp_okay;

	assign b_busy = b_pend;
	assign r_busy = r_pend;

endmodule

// File: hw/axil_slave_port.sv
/* AXI4-Lite slave port: holds AW, W and AR, decodes the timer region
   and issues one-cycle register accesses, writes before reads */
`timescale 1ns/100ps

module axil_slave_port (
	input  logic                      clk,
	input  logic                      rst_n,
	input  soc_bus_pkg::axil_aw_t     aw,
	input  soc_bus_pkg::axil_w_t      w,
	input  soc_bus_pkg::axil_ar_t     ar,
	output logic                      awready,
	output logic                      wready,
	output logic                      arready,
	input  logic                      b_busy,
	input  logic                      r_busy,
	output soc_timer_pkg::reg_access_t access,
	output logic                      err_req
);

	logic                   aw_full;
	logic                   w_full;
	logic                   ar_full;
	soc_bus_pkg::axil_addr_t aw_addr;
	soc_bus_pkg::axil_addr_t ar_addr;
	soc_bus_pkg::axil_data_t w_data;
	soc_bus_pkg::axil_strb_t w_strb;

	logic                   aw_take;
	logic                   w_take;
	logic                   ar_take;
	logic                   wr_go;
	logic                   rd_go;
	logic                   aw_full_next;
	logic                   w_full_next;
	logic                   ar_full_next;
	logic                   aw_hit;
	logic                   ar_hit;
	soc_bus_pkg::addr_view_u aw_view;
	soc_bus_pkg::addr_view_u ar_view;

	assign aw_take = aw.valid & awready;
	assign w_take  = w.valid & wready;
	assign ar_take = ar.valid & arready;

	// write needs both halves and a free response slot
	assign wr_go = aw_full & w_full & ~b_busy;
	assign rd_go = ar_full & ~r_busy & ~wr_go;

	assign aw_full_next = (aw_full & ~wr_go) | aw_take;
	assign w_full_next  = (w_full & ~wr_go) | w_take;
	assign ar_full_next = (ar_full & ~rd_go) | ar_take;

	// ------------------------------------------------------------------
	// holding slots

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aw_full <= 1'b0;
			w_full  <= 1'b0;
			ar_full <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			arready <= 1'b0;
		end else begin
			aw_full <= aw_full_next;
			w_full  <= w_full_next;
			ar_full <= ar_full_next;
			// ready means the slot is empty next cycle
			awready <= ~aw_full_next;
			wready  <= ~w_full_next;
			arready <= ~ar_full_next;
		end
	end

	always_ff @(posedge clk) begin
		if (aw_take) begin
			aw_addr <= aw.addr;
		end
		if (w_take) begin
			w_data <= w.data;
			w_strb <= w.strb;
		end
		if (ar_take) begin
			ar_addr <= ar.addr;
		end
	end

	// ------------------------------------------------------------------
	// region decode and access issue

	assign aw_view.raw = aw_addr;
	assign ar_view.raw = ar_addr;
	assign aw_hit = (aw_view.f.region == soc_bus_pkg::timer_region);
	assign ar_hit = (ar_view.f.region == soc_bus_pkg::timer_region);

	always_comb begin
		access.wen        = wr_go;
		access.ren        = rd_go;
		access.reg_offset = wr_go ? aw_view.f.reg_offset : ar_view.f.reg_offset;
		access.wdata      = w_data;
		// a miss carries no strobes so the timer stays untouched
		access.strb       = (wr_go && aw_hit) ? w_strb : 4'b0000;
		err_req           = (wr_go & ~aw_hit) | (rd_go & ~ar_hit);
	end

endmodule

// File: hw/riscv_mtimer.sv
/* RISC-V machine timer: microsecond timebase, mtime/mtimecmp with
   byte strobes, debug halt freeze and the timer interrupt */
`timescale 1ns/100ps

module riscv_mtimer (
	input  logic                       clk,
	input  logic                       rst_n,
	input  soc_timer_pkg::reg_access_t access,
	input  logic                       dbg_halt,
	output soc_bus_pkg::axil_data_t    rdata,
	output logic                       timer_irq
);

	logic [$clog2(soc_timer_pkg::clk_mhz)-1:0] tick_ctr;
	logic        tick;
	logic        ctrl_en;
	logic [63:0] mtime;
	logic [63:0] mtime_next;
	logic [63:0] mtimecmp;
	logic        count_en;

	logic        wr_ctrl;
	logic        wr_lo;
	logic        wr_hi;
	logic        wr_cmp_lo;
	logic        wr_cmp_hi;

	function automatic logic [31:0] merge_bytes(
		input logic [31:0] old_word,
		input logic [31:0] new_word,
		input logic [3:0]  strb
	);
		logic [31:0] result;
		result = old_word;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				result[8*i +: 8] = new_word[8*i +: 8];
			end
		end
		return result;
	endfunction

	// ------------------------------------------------------------------
	// microsecond timebase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_ctr <= '0;
			tick     <= 1'b0;
		end else begin
			if (|tick_ctr) begin
				tick_ctr <= tick_ctr - 1'b1;
			end else begin
				tick_ctr <= $bits(tick_ctr)'(soc_timer_pkg::clk_mhz - 1);
			end
			tick <= ~|tick_ctr;
		end
	end

	// frozen while the hart sits in debug
	assign count_en = tick & ctrl_en & ~dbg_halt;

	assign wr_ctrl   = access.wen && (access.reg_offset == soc_timer_pkg::off_ctrl);
	assign wr_lo     = access.wen && (access.reg_offset == soc_timer_pkg::off_mtime);
	assign wr_hi     = access.wen && (access.reg_offset == soc_timer_pkg::off_mtimeh);
	assign wr_cmp_lo = access.wen && (access.reg_offset == soc_timer_pkg::off_mtimecmp);
	assign wr_cmp_hi = access.wen && (access.reg_offset == soc_timer_pkg::off_mtimecmph);

	// bus write wins over the increment
	always_comb begin
		mtime_next = mtime;
		if (count_en) begin
			mtime_next = mtime + 64'd1;
		end
		if (wr_lo) begin
			mtime_next = {mtime[63:32], merge_bytes(mtime[31:0], access.wdata, access.strb)};
		end
		if (wr_hi) begin
			mtime_next = {merge_bytes(mtime[63:32], access.wdata, access.strb), mtime[31:0]};
		end
	end

	// ------------------------------------------------------------------
	// registers and interrupt

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_en   <= 1'b0;
			mtime     <= 64'd0;
			mtimecmp  <= '1;
			timer_irq <= 1'b0;
		end else begin
			if (wr_ctrl && access.strb[0]) begin
				ctrl_en <= access.wdata[0];
			end
			mtime <= mtime_next;
			if (wr_cmp_lo) begin
				mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], access.wdata, access.strb);
			end
			if (wr_cmp_hi) begin
				mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], access.wdata, access.strb);
			end
			timer_irq <= (mtime >= mtimecmp);
		end
	end

	// read data held until the next read
	always_ff @(posedge clk) begin
		if (access.ren) begin
			case (access.reg_offset)
				soc_timer_pkg::off_ctrl:      rdata <= {31'd0, ctrl_en};
				soc_timer_pkg::off_mtime:     rdata <= mtime[31:0];
				soc_timer_pkg::off_mtimeh:    rdata <= mtime[63:32];
				soc_timer_pkg::off_mtimecmp:  rdata <= mtimecmp[31:0];
				soc_timer_pkg::off_mtimecmph: rdata <= mtimecmp[63:32];
				default:                      rdata <= '0;
			endcase
		end
	end

endmodule

// File: hw/soc_bus_pkg.sv
/* SoC bus definitions: AXI4-Lite channel payloads, response codes
   and the address decode view used by the timer slave */
package soc_bus_pkg;

	typedef logic [31:0] axil_addr_t;
	typedef logic [31:0] axil_data_t;
	typedef logic [3:0]  axil_strb_t;
	typedef logic [1:0]  axil_resp_t;

	localparam axil_resp_t resp_okay   = 2'b00;
	localparam axil_resp_t resp_slverr = 2'b10;
	localparam axil_resp_t resp_decerr = 2'b11;

	// ------------------------------------------------------------------
	// channel payloads, valid travels with the payload

	typedef struct packed {
		logic       valid;
		axil_addr_t addr;
	} axil_aw_t;

	typedef struct packed {
		logic       valid;
		axil_data_t data;
		axil_strb_t strb;
	} axil_w_t;

	typedef struct packed {
		logic       valid;
		axil_addr_t addr;
	} axil_ar_t;

	typedef struct packed {
		logic       valid;
		axil_resp_t resp;
	} axil_b_t;

	typedef struct packed {
		logic       valid;
		axil_data_t data;
		axil_resp_t resp;
	} axil_r_t;

	// ------------------------------------------------------------------
	// address word, raw or split into region / word index / byte lane

	typedef union packed {
		axil_addr_t raw;
		struct packed {
			logic [15:0] region;
			logic [13:0] reg_offset;
			logic [1:0]  byte_lane;
		} f;
	} addr_view_u;

	// system timer lives at 0x4000_xxxx
	localparam logic [15:0] timer_region = 16'h4000;

endpackage

// File: hw/soc_timer_pkg.sv
/* machine timer definitions: register map, timebase divide
   and the register access handed from the bus port to the timer */
package soc_timer_pkg;

	// clock cycles per microsecond tick
	localparam int clk_mhz = 27;

	// word index within the timer region
	localparam logic [13:0] off_ctrl      = 14'd0;
	localparam logic [13:0] off_mtime     = 14'd2;
	localparam logic [13:0] off_mtimeh    = 14'd3;
	localparam logic [13:0] off_mtimecmp  = 14'd4;
	localparam logic [13:0] off_mtimecmph = 14'd5;

	// one-cycle register access, at most one of wen/ren set
	typedef struct packed {
		logic        wen;
		logic        ren;
		logic [13:0] reg_offset;
		logic [31:0] wdata;
		logic [3:0]  strb;
	} reg_access_t;

endpackage

// File: hw/timer_subsys_top.sv
/* timer subsystem: AXI4-Lite slave port, machine timer and response channels */
`timescale 1ns/100ps

module timer_subsys_top (
	input  logic                  clk,
	input  logic                  rst_n,
	input  soc_bus_pkg::axil_aw_t aw,
	input  soc_bus_pkg::axil_w_t  w,
	input  soc_bus_pkg::axil_ar_t ar,
	output logic                  awready,
	output logic                  wready,
	output logic                  arready,
	output soc_bus_pkg::axil_b_t  b,
	output soc_bus_pkg::axil_r_t  r,
	input  logic                  bready,
	input  logic                  rready,
	input  logic                  dbg_halt,
	output logic                  timer_irq
);

	soc_timer_pkg::reg_access_t access;
	logic                       err_req;
	soc_bus_pkg::axil_data_t    rdata;
	logic                       b_busy;
	logic                       r_busy;

	axil_slave_port port_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.aw      (aw),
		.w       (w),
		.ar      (ar),
		.awready (awready),
		.wready  (wready),
		.arready (arready),
		.b_busy  (b_busy),
		.r_busy  (r_busy),
		.access  (access),
		.err_req (err_req)
	);

	riscv_mtimer timer_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.access    (access),
		.dbg_halt  (dbg_halt),
		.rdata     (rdata),
		.timer_irq (timer_irq)
	);

	axil_resp_channels resp_u (
		.clk     (clk),
		.rst_n   (rst_n),
		.access  (access),
		.err_req (err_req),
		.rdata   (rdata),
		.bready  (bready),
		.rready  (rready),
		.b       (b),
		.r       (r),
		.b_busy  (b_busy),
		.r_busy  (r_busy)
	);

endmodule

// File: testbench/tb_timer_subsys.sv
/* testbench for the timer subsystem: AXI4-Lite master run from a
   test data file, with random back-pressure and typed checks */
`timescale 1ns/100ps

module tb_timer_subsys;

	localparam int timeout_cycles = 1000;

	logic                  clk;
	logic                  rst_n;
	soc_bus_pkg::axil_aw_t aw;
	soc_bus_pkg::axil_w_t  w;
	soc_bus_pkg::axil_ar_t ar;
	logic                  awready;
	logic                  wready;
	logic                  arready;
	soc_bus_pkg::axil_b_t  b;
	soc_bus_pkg::axil_r_t  r;
	logic                  bready;
	logic                  rready;
	logic                  dbg_halt;
	logic                  timer_irq;
	int                    seed = 41;

	timer_subsys_top uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.aw        (aw),
		.w         (w),
		.ar        (ar),
		.awready   (awready),
		.wready    (wready),
		.arready   (arready),
		.b         (b),
		.r         (r),
		.bready    (bready),
		.rready    (rready),
		.dbg_halt  (dbg_halt),
		.timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// failure reporting and checks

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_fail(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_resp(
		input soc_bus_pkg::axil_resp_t got,
		input soc_bus_pkg::axil_resp_t expected,
		input string                   what
	);
		if (got !== expected) begin
			report_fail($sformatf("%s response %0d, expected %0d", what, got, expected));
		end
	endtask

	task automatic check_data(
		input soc_bus_pkg::axil_data_t got,
		input soc_bus_pkg::axil_data_t expected,
		input string                   what
	);
		if (got !== expected) begin
			report_fail($sformatf("%s: got %h, expected %h", what, got, expected));
		end
	endtask

	task automatic check_irq(input logic got, input logic expected, input string what);
		if (got !== expected) begin
			report_fail($sformatf("%s: got %b, expected %b", what, got, expected));
		end
	endtask

	// one step past the rising edge, where outputs are settled
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ----------------------------------------------------------------------
	// bus master

	task automatic axil_write(
		input  soc_bus_pkg::axil_addr_t addr,
		input  soc_bus_pkg::axil_data_t data,
		input  soc_bus_pkg::axil_strb_t strb,
		output soc_bus_pkg::axil_resp_t resp
	);
		int   gap;
		int   hold;
		int   cnt;
		logic aw_first;
		logic aw_done;
		logic w_done;
		logic aw_hs;
		logic w_hs;
		gap      = $unsigned($random(seed)) % 4;
		aw_first = ($random(seed) % 2) != 0;
		aw.addr  = addr;
		w.data   = data;
		w.strb   = strb;
		aw_done  = 1'b0;
		w_done   = 1'b0;
		cnt      = 0;
		// second channel follows gap cycles after the first
		while (!(aw_done && w_done)) begin
			aw.valid = !aw_done && (aw_first || cnt >= gap);
			w.valid  = !w_done && (!aw_first || cnt >= gap);
			aw_hs    = aw.valid && awready;
			w_hs     = w.valid && wready;
			next_cycle();
			aw_done = aw_done || aw_hs;
			w_done  = w_done || w_hs;
			cnt++;
			if (cnt > timeout_cycles) begin
				abort_run("write address or data was never accepted");
			end
		end
		aw.valid = 1'b0;
		w.valid  = 1'b0;
		hold     = $unsigned($random(seed)) % 5;
		bready   = 1'b0;
		cnt      = 0;
		while (!(b.valid && bready)) begin
			next_cycle();
			cnt++;
			if (cnt >= hold) begin
				bready = 1'b1;
			end
			if (cnt > timeout_cycles) begin
				abort_run("no write response arrived");
			end
		end
		resp = b.resp;
		next_cycle();
		bready = 1'b0;
		if (b.valid) begin
			report_fail("write channel gave a second response");
		end
	endtask

	task automatic axil_read(
		input  soc_bus_pkg::axil_addr_t addr,
		output soc_bus_pkg::axil_data_t data,
		output soc_bus_pkg::axil_resp_t resp
	);
		int hold;
		int cnt;
		ar.addr  = addr;
		ar.valid = 1'b1;
		cnt      = 0;
		while (!arready) begin
			next_cycle();
			cnt++;
			if (cnt > timeout_cycles) begin
				abort_run("read address was never accepted");
			end
		end
		next_cycle();
		ar.valid = 1'b0;
		hold     = $unsigned($random(seed)) % 5;
		rready   = 1'b0;
		cnt      = 0;
		while (!(r.valid && rready)) begin
			next_cycle();
			cnt++;
			if (cnt >= hold) begin
				rready = 1'b1;
			end
			if (cnt > timeout_cycles) begin
				abort_run("no read response arrived");
			end
		end
		data = r.data;
		resp = r.resp;
		next_cycle();
		rready = 1'b0;
		if (r.valid) begin
			report_fail("read channel gave a second response");
		end
	endtask

	task automatic read_expect(
		input soc_bus_pkg::axil_addr_t addr,
		input soc_bus_pkg::axil_data_t expected,
		input string                   what
	);
		soc_bus_pkg::axil_data_t got_data;
		soc_bus_pkg::axil_resp_t got_resp;
		axil_read(addr, got_data, got_resp);
		check_resp(got_resp, soc_bus_pkg::resp_okay, what);
		check_data(got_data, expected, what);
	endtask

	// limit 0 means the level must already be there
	task automatic wait_irq(input logic expected, input int limit);
		int cnt;
		cnt = 0;
		while (limit > 0 && timer_irq !== expected) begin
			next_cycle();
			cnt++;
			if (cnt > limit) begin
				abort_run("timer interrupt did not reach the expected level in time");
			end
		end
		check_irq(timer_irq, expected, "timer_irq level");
	endtask

	task automatic compare_later(
		input soc_bus_pkg::axil_addr_t addr,
		input int                      gap,
		input logic                    expect_growth,
		input soc_bus_pkg::axil_resp_t exp_resp
	);
		soc_bus_pkg::axil_data_t first;
		soc_bus_pkg::axil_data_t second;
		soc_bus_pkg::axil_resp_t resp;
		axil_read(addr, first, resp);
		check_resp(resp, exp_resp, "first sample");
		repeat (gap) begin
			next_cycle();
		end
		axil_read(addr, second, resp);
		check_resp(resp, exp_resp, "second sample");
		if (expect_growth) begin
			if (second <= first) begin
				report_fail($sformatf("count did not advance: %h then %h", first, second));
			end
		end else begin
			check_data(second, first, "count while halted");
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence driven line by line from the data file

	initial begin
		int                      fd;
		int                      fields;
		string                   line;
		string                   op;
		soc_bus_pkg::axil_addr_t addr;
		soc_bus_pkg::axil_data_t data;
		soc_bus_pkg::axil_strb_t strb;
		soc_bus_pkg::axil_data_t exp_data;
		soc_bus_pkg::axil_resp_t exp_resp;
		soc_bus_pkg::axil_data_t got_data;
		soc_bus_pkg::axil_resp_t got_resp;
		rst_n    = 1'b0;
		aw       = '0;
		w        = '0;
		ar       = '0;
		bready   = 1'b0;
		rready   = 1'b0;
		dbg_halt = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		// handshake outputs and interrupt sit low in reset
		check_irq(awready, 1'b0, "awready in reset");
		check_irq(wready, 1'b0, "wready in reset");
		check_irq(arready, 1'b0, "arready in reset");
		check_irq(b.valid, 1'b0, "bvalid in reset");
		check_irq(r.valid, 1'b0, "rvalid in reset");
		check_irq(timer_irq, 1'b0, "timer_irq in reset");
		rst_n = 1'b1;
		next_cycle();
		// counting is off, so reset contents are still there
		read_expect(32'h4000_0000, 32'h0000_0000, "ctrl after reset");
		read_expect(32'h4000_0008, 32'h0000_0000, "mtime after reset");
		read_expect(32'h4000_000c, 32'h0000_0000, "mtimeh after reset");
		read_expect(32'h4000_0010, 32'hffff_ffff, "mtimecmp after reset");
		read_expect(32'h4000_0014, 32'hffff_ffff, "mtimecmph after reset");
		fd = $fopen("testbench/timer_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open testbench/timer_testdata.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.substr(0, 0) == "#") begin
				continue;
			end
			fields = $sscanf(line, "%s %h %h %h %h %h",
				op, addr, data, strb, exp_data, exp_resp);
			if (fields != 6) begin
				abort_run($sformatf("malformed test data line: %s", line));
			end
			if (op == "write") begin
				axil_write(addr, data, strb, got_resp);
				check_resp(got_resp, exp_resp, $sformatf("write to %h", addr));
			end else if (op == "read") begin
				axil_read(addr, got_data, got_resp);
				check_resp(got_resp, exp_resp, $sformatf("read of %h", addr));
				check_data(got_data, exp_data, $sformatf("read of %h", addr));
			end else if (op == "wait_irq") begin
				wait_irq(exp_data[0], int'(data));
			end else if (op == "halt") begin
				dbg_halt = 1'b1;
			end else if (op == "release") begin
				dbg_halt = 1'b0;
			end else if (op == "compare_later") begin
				compare_later(addr, int'(data), exp_data[0], exp_resp);
			end else begin
				abort_run($sformatf("unknown operation %s in test data", op));
			end
		end
		$fclose(fd);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: testbench/timer_testdata.txt
# columns: op addr data strb exp_data exp_resp, all hex
# data is a cycle count for wait_irq and compare_later; exp_data 1 there means high or growing
write         40000008 12345678 f 0        0
read          40000008 0        0 12345678 0
write         4000000c 00000abc f 0        0
read          4000000c 0        0 00000abc 0
write         40000010 55667788 f 0        0
read          40000010 0        0 55667788 0
write         40000014 00000001 f 0        0
read          40000014 0        0 00000001 0
write         40000008 aabbccdd 5 0        0
read          40000008 0        0 12bb56dd 0
read          40000004 0        0 0        0
write         50000008 ffffffff f 0        3
read          50000008 0        0 0        3
read          40000008 0        0 12bb56dd 0
write         4000000c 00000000 f 0        0
write         40000000 00000001 1 0        0
compare_later 40000008 64       0 1        0
halt          0        0        0 0        0
compare_later 40000008 64       0 0        0
release       0        0        0 0        0
compare_later 40000008 64       0 1        0
write         40000000 00000000 1 0        0
write         40000008 00000100 f 0        0
write         40000010 00000102 f 0        0
write         40000014 00000000 f 0        0
wait_irq      0        0        0 0        0
write         40000000 00000001 1 0        0
wait_irq      0        0        0 0        0
wait_irq      0        c8       0 1        0
write         40000014 00000001 f 0        0
wait_irq      0        10       0 0        0
